// ==== include/rename_consts.svh ====
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// register file sizes
`define NUM_ARCH_REG 16
`define NUM_PHYS_REG 32

// in-flight allocation records
`define ROB_DEPTH 8

// opcodes, bits 15:12 of the instruction word
`define OP_ALU  4'h0
// second source field holds an immediate
`define OP_ALUI 4'h1
`define OP_LDR  4'h2
// no destination write for the three below
`define OP_STR  4'h3
`define OP_BCC  4'h4
`define OP_NOP  4'hf

`endif

// ==== logic/rename_pkg.sv ====
`include "rename_consts.svh"

package rename_pkg;

  // index and count widths
  typedef logic [$clog2(`NUM_ARCH_REG)-1:0] arch_reg_t;
  typedef logic [$clog2(`NUM_PHYS_REG)-1:0] phys_reg_t;
  typedef logic [$clog2(`ROB_DEPTH)-1:0]    rob_idx_t;
  typedef logic [$clog2(`NUM_PHYS_REG):0]   fl_count_t;
  typedef logic [3:0]                       opcode_t;

  // raw word: opcode, dest, src1, src2 or immediate
  typedef logic [15:0] instr_word_t;

  typedef struct packed {
    opcode_t   opcode;
    arch_reg_t dest;
    arch_reg_t src1;
    arch_reg_t src2_imm;
    logic      use_imm;
    logic      w_v;
    logic      is_branch;
  } decoded_instr_t;

  // src2_imm is a physical register or the zero-extended immediate
  typedef struct packed {
    opcode_t   opcode;
    phys_reg_t phys_dest;
    phys_reg_t phys_src1;
    phys_reg_t src2_imm;
    logic      use_imm;
    logic      w_v;
    rob_idx_t  rob_tag;
  } renamed_instr_t;

  // one allocation record, kept in program order
  typedef struct packed {
    arch_reg_t arch_dest;
    phys_reg_t new_phys;
    phys_reg_t old_phys;
    logic      w_v;
    logic      is_branch;
  } rob_entry_t;

  // retire payload back to rename
  typedef struct packed {
    arch_reg_t arch_dest;
    phys_reg_t new_phys;
    phys_reg_t old_phys;
    logic      w_v;
  } commit_t;

endpackage

// ==== logic/decode_stage.sv ====
`timescale 1ns/100ps
`include "rename_consts.svh"

module decode_stage (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       flush_i,
  input  rename_pkg::instr_word_t    instr_i,
  input  logic                       instr_v_i,
  output logic                       instr_ready_o,
  output rename_pkg::decoded_instr_t dec_o,
  output logic                       dec_v_o,
  input  logic                       dec_ready_i
);

  rename_pkg::decoded_instr_t dec_n;
  rename_pkg::decoded_instr_t dec_q;
  rename_pkg::opcode_t        opcode;
  logic                       dec_v_q;
  logic                       take;

  assign opcode = instr_i[15:12];

  // room when empty or when rename drains us this cycle
  assign instr_ready_o = !dec_v_q || dec_ready_i;
  assign take          = instr_v_i && instr_ready_o;

  always_comb begin
    dec_n.opcode    = opcode;
    dec_n.dest      = instr_i[11:8];
    dec_n.src1      = instr_i[7:4];
    dec_n.src2_imm  = instr_i[3:0];
    dec_n.use_imm   = 1'b0;
    dec_n.w_v       = 1'b0;
    dec_n.is_branch = 1'b0;
    case (opcode)
      `OP_ALU, `OP_LDR: begin
        dec_n.w_v = 1'b1;
      end
      `OP_ALUI: begin
        dec_n.w_v     = 1'b1;
        dec_n.use_imm = 1'b1;
      end
      `OP_BCC: begin
        dec_n.is_branch = 1'b1;
      end
      // stores, nops and unknown codes write nothing
      `OP_STR, `OP_NOP: begin
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      dec_v_q <= 1'b0;
    end else if (instr_ready_o) begin
      dec_v_q <= take;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      dec_q <= dec_n;
    end
  end

  assign dec_o   = dec_q;
  assign dec_v_o = dec_v_q;

endmodule

// ==== logic/rename_stage.sv ====
`timescale 1ns/100ps
`include "rename_consts.svh"

module rename_stage (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       mispredict_i,
  input  rename_pkg::decoded_instr_t dec_i,
  input  logic                       dec_v_i,
  output logic                       dec_ready_o,
  output rename_pkg::renamed_instr_t renamed_o,
  output logic                       renamed_v_o,
  input  logic                       issue_ready_i,
  output rename_pkg::rob_entry_t     alloc_o,
  output logic                       alloc_v_o,
  input  rename_pkg::rob_idx_t       rob_tag_i,
  input  logic                       rob_full_i,
  input  rename_pkg::commit_t        commit_i,
  input  logic                       commit_v_i
);

  // map tables, speculative and committed
  rename_pkg::phys_reg_t spec_map [`NUM_ARCH_REG];
  rename_pkg::phys_reg_t com_map  [`NUM_ARCH_REG];

  // circular free lists; pointers share the physical index width
  rename_pkg::phys_reg_t spec_fl [`NUM_PHYS_REG];
  rename_pkg::phys_reg_t com_fl  [`NUM_PHYS_REG];
  rename_pkg::phys_reg_t spec_head;
  rename_pkg::phys_reg_t spec_tail;
  rename_pkg::phys_reg_t com_head;
  rename_pkg::phys_reg_t com_tail;
  rename_pkg::fl_count_t spec_count;

  rename_pkg::renamed_instr_t renamed_n;
  rename_pkg::renamed_instr_t renamed_q;
  logic                       renamed_v_q;

  rename_pkg::phys_reg_t new_phys;
  rename_pkg::phys_reg_t old_phys;
  logic                  out_free;
  logic                  accept;
  logic                  alloc_w;
  logic                  free_w;

  assign out_free    = !renamed_v_q || issue_ready_i;
  assign dec_ready_o = out_free && !rob_full_i && (spec_count != '0) && !mispredict_i;
  assign accept      = dec_v_i && dec_ready_o;
  assign alloc_w     = accept && dec_i.w_v;
  assign free_w      = commit_v_i && commit_i.w_v;

  assign new_phys = spec_fl[spec_head];
  assign old_phys = spec_map[dec_i.dest];

  always_comb begin
    renamed_n.opcode    = dec_i.opcode;
    // non-writing ops carry the current mapping, e.g. store data
    renamed_n.phys_dest = dec_i.w_v ? new_phys : old_phys;
    renamed_n.phys_src1 = spec_map[dec_i.src1];
    if (dec_i.use_imm) begin
      renamed_n.src2_imm = {1'b0, dec_i.src2_imm};
    end else begin
      renamed_n.src2_imm = spec_map[dec_i.src2_imm];
    end
    renamed_n.use_imm   = dec_i.use_imm;
    renamed_n.w_v       = dec_i.w_v;
    renamed_n.rob_tag   = rob_tag_i;
  end

  always_comb begin
    alloc_o.arch_dest = dec_i.dest;
    alloc_o.new_phys  = renamed_n.phys_dest;
    alloc_o.old_phys  = old_phys;
    alloc_o.w_v       = dec_i.w_v;
    alloc_o.is_branch = dec_i.is_branch;
  end

  assign alloc_v_o = accept;

  // speculative side
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `NUM_ARCH_REG; i++) begin
        spec_map[i] <= rename_pkg::phys_reg_t'(i);
      end
      for (int i = 0; i < `NUM_PHYS_REG; i++) begin
        spec_fl[i] <= rename_pkg::phys_reg_t'(i + `NUM_ARCH_REG);
      end
      spec_head  <= '0;
      spec_tail  <= rename_pkg::phys_reg_t'(`NUM_PHYS_REG - `NUM_ARCH_REG);
      spec_count <= rename_pkg::fl_count_t'(`NUM_PHYS_REG - `NUM_ARCH_REG);
    end else if (mispredict_i) begin
      // roll back to the committed picture
      spec_map   <= com_map;
      spec_fl    <= com_fl;
      spec_head  <= com_head;
      spec_tail  <= com_tail;
      // every register outside the committed map is free
      spec_count <= rename_pkg::fl_count_t'(`NUM_PHYS_REG - `NUM_ARCH_REG);
    end else begin
      if (alloc_w) begin
        spec_map[dec_i.dest] <= new_phys;
        spec_head            <= spec_head + 1'b1;
      end
      if (free_w) begin
        spec_fl[spec_tail] <= commit_i.old_phys;
        spec_tail          <= spec_tail + 1'b1;
      end
      case ({alloc_w, free_w})
        2'b10:   spec_count <= spec_count - 1'b1;
        2'b01:   spec_count <= spec_count + 1'b1;
        default: spec_count <= spec_count;
      endcase
    end
  end

  // committed side, moves only on retire
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `NUM_ARCH_REG; i++) begin
        com_map[i] <= rename_pkg::phys_reg_t'(i);
      end
      for (int i = 0; i < `NUM_PHYS_REG; i++) begin
        com_fl[i] <= rename_pkg::phys_reg_t'(i + `NUM_ARCH_REG);
      end
      com_head <= '0;
      com_tail <= rename_pkg::phys_reg_t'(`NUM_PHYS_REG - `NUM_ARCH_REG);
    end else if (free_w) begin
      // the head entry is the register this record took
      com_map[commit_i.arch_dest] <= commit_i.new_phys;
      com_fl[com_tail]            <= commit_i.old_phys;
      com_head                    <= com_head + 1'b1;
      com_tail                    <= com_tail + 1'b1;
    end
  end

  // output register toward issue
  always_ff @(posedge clk_i) begin
    if (reset_i || mispredict_i) begin
      renamed_v_q <= 1'b0;
    end else if (out_free) begin
      renamed_v_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      renamed_q <= renamed_n;
    end
  end

  assign renamed_o   = renamed_q;
  assign renamed_v_o = renamed_v_q;

endmodule

// ==== logic/reorder_queue.sv ====
`timescale 1ns/100ps
`include "rename_consts.svh"

module reorder_queue (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   mispredict_i,
  input  rename_pkg::rob_entry_t alloc_i,
  input  logic                   alloc_v_i,
  output rename_pkg::rob_idx_t   rob_tag_o,
  output logic                   rob_full_o,
  input  logic                   complete_i,
  output rename_pkg::commit_t    commit_o,
  output logic                   commit_v_o
);

  rename_pkg::rob_entry_t entries [`ROB_DEPTH];
  rename_pkg::rob_entry_t head_entry;
  rename_pkg::rob_idx_t   head;
  rename_pkg::rob_idx_t   tail;
  logic [$clog2(`ROB_DEPTH):0] count;
  logic                   empty;
  logic                   push;
  logic                   pop;

  assign empty      = (count == '0);
  assign rob_full_o = (count == `ROB_DEPTH);
  // next record lands at the tail
  assign rob_tag_o  = tail;

  assign push       = alloc_v_i && !rob_full_o && !mispredict_i;
  assign pop        = complete_i && !empty && !mispredict_i;
  assign commit_v_o = pop;

  // oldest record, seen combinationally
  assign head_entry        = entries[head];
  assign commit_o.arch_dest = head_entry.arch_dest;
  assign commit_o.new_phys  = head_entry.new_phys;
  assign commit_o.old_phys  = head_entry.old_phys;
  assign commit_o.w_v       = head_entry.w_v;

  always_ff @(posedge clk_i) begin
    if (reset_i || mispredict_i) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        tail <= tail + 1'b1;
      end
      if (pop) begin
        head <= head + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      entries[tail] <= alloc_i;
    end
  end

endmodule

// ==== logic/rename_top.sv ====
`timescale 1ns/100ps

module rename_top (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  rename_pkg::instr_word_t    instr_i,
  input  logic                       instr_v_i,
  output logic                       instr_ready_o,
  output rename_pkg::renamed_instr_t renamed_o,
  output logic                       renamed_v_o,
  input  logic                       issue_ready_i,
  input  logic                       complete_i,
  input  logic                       mispredict_i
);

  // decode to rename
  rename_pkg::decoded_instr_t dec;
  logic                       dec_v;
  logic                       dec_ready;

  // rename and reorder queue
  rename_pkg::rob_entry_t alloc;
  logic                   alloc_v;
  rename_pkg::rob_idx_t   rob_tag;
  logic                   rob_full;
  rename_pkg::commit_t    commit;
  logic                   commit_v;

  decode_stage decode_stage_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .flush_i       (mispredict_i),
    .instr_i       (instr_i),
    .instr_v_i     (instr_v_i),
    .instr_ready_o (instr_ready_o),
    .dec_o         (dec),
    .dec_v_o       (dec_v),
    .dec_ready_i   (dec_ready)
  );

  rename_stage rename_stage_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .mispredict_i  (mispredict_i),
    .dec_i         (dec),
    .dec_v_i       (dec_v),
    .dec_ready_o   (dec_ready),
    .renamed_o     (renamed_o),
    .renamed_v_o   (renamed_v_o),
    .issue_ready_i (issue_ready_i),
    .alloc_o       (alloc),
    .alloc_v_o     (alloc_v),
    .rob_tag_i     (rob_tag),
    .rob_full_i    (rob_full),
    .commit_i      (commit),
    .commit_v_i    (commit_v)
  );

  reorder_queue reorder_queue_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .mispredict_i (mispredict_i),
    .alloc_i      (alloc),
    .alloc_v_i    (alloc_v),
    .rob_tag_o    (rob_tag),
    .rob_full_o   (rob_full),
    .complete_i   (complete_i),
    .commit_o     (commit),
    .commit_v_o   (commit_v)
  );

endmodule

// ==== sim/rename_tb.sv ====
`timescale 1ns/100ps
`include "rename_consts.svh"

module rename_tb;

  typedef struct packed {
    logic [15:0] word;
    logic        v;
    logic        ir;
    logic        cmp;
    logic        mp;
    logic [2:0]  test;
  } step_t;

  logic clk_i = 1'b0;
  logic reset_i;
  rename_pkg::instr_word_t    instr_i;
  logic                       instr_v_i;
  logic                       instr_ready_o;
  rename_pkg::renamed_instr_t renamed_o;
  logic                       renamed_v_o;
  logic                       issue_ready_i;
  logic                       complete_i;
  logic                       mispredict_i;

  step_t table_q[$];
  int    cur_test;
  int    checks;
  int    errors;
  int    test_err[5];
  int    cycles;
  int    max_cycles = 100;
  logic  saw_stall;

  // reference model state
  rename_pkg::phys_reg_t      spec_map[`NUM_ARCH_REG];
  rename_pkg::phys_reg_t      com_map[`NUM_ARCH_REG];
  rename_pkg::phys_reg_t      spec_fl[$];
  rename_pkg::phys_reg_t      com_fl[$];
  rename_pkg::rob_entry_t     pend_q[$];
  rename_pkg::renamed_instr_t exp_q[$];
  rename_pkg::rob_idx_t       m_tail;
  logic                       m_dec_v;
  logic                       m_ren_v;
  logic [15:0]                m_dec_word;

  rename_top rename_top_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_i       (instr_i),
    .instr_v_i     (instr_v_i),
    .instr_ready_o (instr_ready_o),
    .renamed_o     (renamed_o),
    .renamed_v_o   (renamed_v_o),
    .issue_ready_i (issue_ready_i),
    .complete_i    (complete_i),
    .mispredict_i  (mispredict_i)
  );

  always #10 clk_i = ~clk_i;

  function automatic logic [15:0] mk(logic [3:0] op, logic [3:0] d, logic [3:0] s1,
                                     logic [3:0] s2);
    return {op, d, s1, s2};
  endfunction

  task automatic add_step(logic [15:0] w, logic v, logic ir, logic cmp, logic mp, int t);
    step_t st;
    st.word = w;
    st.v    = v;
    st.ir   = ir;
    st.cmp  = cmp;
    st.mp   = mp;
    st.test = 3'(t);
    table_q.push_back(st);
  endtask

  // a few quiet cycles, then retire what is left
  task automatic drain(int t, int n_cmp);
    repeat (4) add_step(16'hf000, 1'b0, 1'b1, 1'b0, 1'b0, t);
    repeat (n_cmp) add_step(16'hf000, 1'b0, 1'b1, 1'b1, 1'b0, t);
  endtask

  task automatic build_table();
    logic [3:0] ops[6];
    ops = '{`OP_ALU, `OP_ALUI, `OP_LDR, `OP_STR, `OP_BCC, `OP_NOP};
    // independent writers straight after reset
    for (int i = 0; i < 6; i++) begin
      add_step(mk(`OP_ALU, 4'(i + 1), 4'(i + 8), 4'(i + 9)), 1'b1, 1'b1, 1'b0, 1'b0, 0);
    end
    drain(0, 6);
    // dependency chain, immediates, non-writers
    add_step(mk(`OP_ALU, 4'd1, 4'd2, 4'd3), 1'b1, 1'b1, 1'b0, 1'b0, 1);
    add_step(mk(`OP_ALUI, 4'd4, 4'd1, 4'd9), 1'b1, 1'b1, 1'b0, 1'b0, 1);
    add_step(mk(`OP_LDR, 4'd5, 4'd4, 4'd0), 1'b1, 1'b1, 1'b0, 1'b0, 1);
    add_step(mk(`OP_STR, 4'd5, 4'd1, 4'd4), 1'b1, 1'b1, 1'b0, 1'b0, 1);
    add_step(mk(`OP_BCC, 4'd0, 4'd5, 4'd1), 1'b1, 1'b1, 1'b0, 1'b0, 1);
    add_step(mk(`OP_NOP, 4'd0, 4'd0, 4'd0), 1'b1, 1'b1, 1'b0, 1'b0, 1);
    add_step(mk(`OP_ALU, 4'd2, 4'd5, 4'd4), 1'b1, 1'b1, 1'b0, 1'b0, 1);
    drain(1, 8);
    // issue stalled, then a full reorder queue, then completions
    for (int i = 0; i < 36; i++) begin
      add_step(mk(`OP_ALU, 4'(i % 15 + 1), 4'(i), 4'(i + 1)), 1'b1, 1'(i >= 10),
               1'(i >= 24), 1'b0, 2);
    end
    drain(2, 12);
    // random mix, long enough to wrap the free list
    for (int i = 0; i < 30; i++) begin
      add_step(mk(ops[$urandom % 6], 4'($urandom), 4'($urandom), 4'($urandom)),
               1'b1, 1'b1, 1'(i % 2), 1'b0, 3);
    end
    drain(3, 10);
    // squash the in-flight work, then rename against committed state
    for (int i = 0; i < 6; i++) begin
      add_step(mk(`OP_ALU, 4'(i + 3), 4'(i + 3), 4'(i)), 1'b1, 1'(i < 4), 1'b0, 1'b0, 4);
    end
    add_step(16'hf000, 1'b0, 1'b0, 1'b0, 1'b1, 4);
    for (int i = 0; i < 4; i++) begin
      add_step(mk(`OP_ALU, 4'(i + 1), 4'(i + 3), 4'(i + 4)), 1'b1, 1'b1, 1'b0, 1'b0, 4);
    end
    drain(4, 10);
  endtask

  task automatic note_error();
    errors++;
    test_err[cur_test]++;
  endtask

  task automatic reset_model();
    spec_fl.delete();
    com_fl.delete();
    for (int i = 0; i < `NUM_ARCH_REG; i++) begin
      spec_map[i] = 5'(i);
      com_map[i]  = 5'(i);
      spec_fl.push_back(5'(i + `NUM_ARCH_REG));
      com_fl.push_back(5'(i + `NUM_ARCH_REG));
    end
    pend_q.delete();
    exp_q.delete();
    m_tail  = '0;
    m_dec_v = 1'b0;
    m_ren_v = 1'b0;
  endtask

  task automatic step_model();
    logic out_free;
    logic dec_ready;
    logic ren_accept;
    logic in_ready;
    logic take;
    logic commit;
    logic [3:0] op;
    logic [3:0] d;
    logic wv;
    logic imm;
    rename_pkg::renamed_instr_t exp_r;
    rename_pkg::rob_entry_t rec;
    out_free   = !m_ren_v || issue_ready_i;
    dec_ready  = out_free && (pend_q.size() != `ROB_DEPTH) && !mispredict_i;
    ren_accept = m_dec_v && dec_ready;
    in_ready   = !m_dec_v || dec_ready;
    take       = instr_v_i && in_ready;
    commit     = complete_i && (pend_q.size() != 0) && !mispredict_i;
    checks += 2;
    assert (instr_ready_o == in_ready) else begin
      $display("[FAIL] %0t instr_ready_o expected %0b got %0b", $time, in_ready, instr_ready_o);
      note_error();
    end
    assert (renamed_v_o == m_ren_v) else begin
      $display("[FAIL] %0t renamed_v_o expected %0b got %0b", $time, m_ren_v, renamed_v_o);
      note_error();
    end
    // output must match and hold until issue takes it
    if (m_ren_v) begin
      checks++;
      assert (renamed_o == exp_q[0]) else begin
        $display("[FAIL] %0t renamed_o expected %h got %h", $time, exp_q[0], renamed_o);
        note_error();
      end
      if (issue_ready_i) begin
        void'(exp_q.pop_front());
      end
    end
    if (mispredict_i) begin
      m_ren_v  = 1'b0;
      m_dec_v  = 1'b0;
      exp_q.delete();
      pend_q.delete();
      spec_map = com_map;
      spec_fl  = com_fl;
      m_tail   = '0;
    end else begin
      if (commit) begin
        rec = pend_q.pop_front();
        if (rec.w_v) begin
          com_map[rec.arch_dest] = rec.new_phys;
          void'(com_fl.pop_front());
          com_fl.push_back(rec.old_phys);
          spec_fl.push_back(rec.old_phys);
        end
      end
      if (ren_accept) begin
        op  = m_dec_word[15:12];
        d   = m_dec_word[11:8];
        wv  = (op == `OP_ALU) || (op == `OP_ALUI) || (op == `OP_LDR);
        imm = (op == `OP_ALUI);
        exp_r.opcode    = op;
        exp_r.phys_dest = wv ? spec_fl[0] : spec_map[d];
        exp_r.phys_src1 = spec_map[m_dec_word[7:4]];
        exp_r.src2_imm  = imm ? {1'b0, m_dec_word[3:0]} : spec_map[m_dec_word[3:0]];
        exp_r.use_imm   = imm;
        exp_r.w_v       = wv;
        exp_r.rob_tag   = m_tail;
        rec.arch_dest   = d;
        rec.new_phys    = exp_r.phys_dest;
        rec.old_phys    = spec_map[d];
        rec.w_v         = wv;
        rec.is_branch   = (op == `OP_BCC);
        exp_q.push_back(exp_r);
        pend_q.push_back(rec);
        if (wv) begin
          spec_map[d] = spec_fl.pop_front();
        end
        m_tail++;
      end
      if (out_free) begin
        m_ren_v = ren_accept;
      end
      if (in_ready) begin
        m_dec_v = take;
      end
      if (take) begin
        m_dec_word = instr_i;
      end
    end
  endtask

  task automatic report_test(int t);
    string name;
    case (t)
      0: name = "identity";
      1: name = "dependency";
      2: name = "backpressure";
      3: name = "reclaim";
      default: name = "rollback";
    endcase
    if (t == 2) begin
      checks++;
      assert (saw_stall) else begin
        $display("instr_ready_o never dropped with a full reorder queue");
        note_error();
      end
    end
    $display("test %0d %s: %0d errors", t, name, test_err[t]);
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      reset_model();
    end else begin
      // with issue ready, only a full reorder queue can hold off decode
      if (cur_test == 2 && issue_ready_i && !instr_ready_o) begin
        saw_stall = 1'b1;
      end
      step_model();
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > max_cycles) begin
      $display("timeout after %0d cycles, run stopped", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    void'($urandom(92130));
    reset_i       = 1'b1;
    instr_i       = '0;
    instr_v_i     = 1'b0;
    issue_ready_i = 1'b0;
    complete_i    = 1'b0;
    mispredict_i  = 1'b0;
    cur_test      = 0;
    checks        = 0;
    errors        = 0;
    cycles        = 0;
    saw_stall     = 1'b0;
    test_err      = '{default: 0};
    build_table();
    max_cycles = table_q.size() * 4 + 100;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    foreach (table_q[i]) begin
      @(negedge clk_i);
      if (int'(table_q[i].test) != cur_test) begin
        report_test(cur_test);
        cur_test = int'(table_q[i].test);
      end
      instr_i       = table_q[i].word;
      instr_v_i     = table_q[i].v;
      issue_ready_i = table_q[i].ir;
      complete_i    = table_q[i].cmp;
      mispredict_i  = table_q[i].mp;
    end
    @(negedge clk_i);
    instr_v_i    = 1'b0;
    complete_i   = 1'b0;
    mispredict_i = 1'b0;
    repeat (3) @(negedge clk_i);
    // nothing may be left waiting for issue
    checks++;
    assert (exp_q.size() == 0) else begin
      $display("%0d renamed instructions never reached the output", exp_q.size());
      note_error();
    end
    report_test(cur_test);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+include
logic/rename_pkg.sv
logic/decode_stage.sv
logic/rename_stage.sv
logic/reorder_queue.sv
logic/rename_top.sv
sim/rename_tb.sv

// ==== Makefile ====
SRCS = $(wildcard logic/*.sv sim/*.sv include/*.svh)

.PHONY: all run clean

all: obj_dir/Vrename_tb

# rebuilt only when a source or the file list changes
obj_dir/Vrename_tb: verilog.f $(SRCS)
	verilator --binary --timing -f verilog.f --top-module rename_tb

# output goes to the terminal, the grep sets the exit status
run: obj_dir/Vrename_tb
	./obj_dir/Vrename_tb | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
